//--- bench/replay_tb_checks.svh
/*
 * Replay testbench checks: typed compare tasks, error counts and the
 * model of the beats the DUT should hold
 */
`ifndef REPLAY_TB_CHECKS_SVH
`define REPLAY_TB_CHECKS_SVH

int unsigned check_count    = 0;
int unsigned value_errors   = 0;
int unsigned timeout_errors = 0;
bit          aborted        = 1'b0;

// Beats the DUT should hold, oldest first
beat_t recorded_q[$];

task automatic check_beat(input string name, input beat_t actual, input beat_t expected);
   check_count++;
   if (actual !== expected) begin
      value_errors++;
      $display("** Error at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
   end
endtask

task automatic check_flag(input string name, input logic actual, input logic expected);
   check_count++;
   if (actual !== expected) begin
      value_errors++;
      $display("** Error at %0d ns: %s = %b, expected %b", $time, name, actual, expected);
   end
endtask

// A wait that runs out also stops the remaining table rows
task automatic report_timeout(input string what, input int limit);
   timeout_errors++;
   aborted = 1'b1;
   $display("Timeout at %0d ns: waited %0d cycles for %s", $time, limit, what);
endtask

// Output and busy must stay low once a replay has drained
task automatic check_idle(input int cycles);
   repeat (cycles) begin
      @(posedge clk);
      m_tready_i <= 1'b1;
      @(negedge clk);
      check_flag("m_tvalid_o", m_tvalid_o, 1'b0);
      check_flag("replay_busy_o", replay_busy_o, 1'b0);
   end
endtask

// Recording stops at the memory depth
function automatic bit model_has_room();
   return recorded_q.size() < DEPTH;
endfunction

// Every pass repeats the stored sequence from its first beat
function automatic beat_t model_expected(input int index);
   return recorded_q[index % recorded_q.size()];
endfunction

`endif

//--- bench/replay_tb.sv
/*
 * Testbench for the record-and-replay buffer: records random beats,
 * replays them and compares the output against a model of the recording
 */
module replay_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import stream_pkg::*;
   import mem_pkg::*;

   localparam int ADDR_W          = 4;
   localparam int FIFO_DEPTH_BITS = 3;
   localparam int DEPTH           = 1 << ADDR_W;
   localparam int unsigned SEED   = 32'h4a848fc4;
   localparam int NUM_ROWS        = 6;

   // Beats offered, passes, random m_tready_i, sw_rst_i first, beats expected out
   typedef struct packed {
      logic [7:0]  n_beats;
      pass_count_t replay_count;
      logic        backpressure;
      logic        sw_rst_first;
      logic [7:0]  exp_out_beats;
   } row_t;

   localparam row_t ROWS [NUM_ROWS] = '{
      '{8'd5,  16'd1, 1'b0, 1'b0, 8'd5},
      '{8'd0,  16'd3, 1'b0, 1'b0, 8'd15},
      '{8'd0,  16'd2, 1'b1, 1'b0, 8'd10},
      '{8'd20, 16'd1, 1'b1, 1'b1, 8'd16},
      '{8'd3,  16'd2, 1'b0, 1'b1, 8'd6},
      '{8'd0,  16'd0, 1'b0, 1'b0, 8'd0}
   };

   logic              clk;
   logic              reset_i;
   logic [DATA_W-1:0] s_tdata_i;
   logic [KEEP_W-1:0] s_tkeep_i;
   logic [USER_W-1:0] s_tuser_i;
   logic              s_tlast_i;
   logic              s_tvalid_i;
   logic              s_tready_o;
   logic [DATA_W-1:0] m_tdata_o;
   logic [KEEP_W-1:0] m_tkeep_o;
   logic [USER_W-1:0] m_tuser_o;
   logic              m_tlast_o;
   logic              m_tvalid_o;
   logic              m_tready_i;
   logic              sw_rst_i;
   logic              wr_done_i;
   logic              start_replay_i;
   pass_count_t       replay_count_i;
   logic              replay_busy_o;

   `include "replay_tb_checks.svh"

   replay_top #(.ADDR_W(ADDR_W), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Offers random beats; ready is expected only while the memory has room
   task automatic record_beats(input int count);
      beat_t beat;
      bit    room;
      for (int i = 0; i < count; i++) begin
         if ($urandom_range(3) == 0) begin
            @(posedge clk);
            s_tvalid_i <= 1'b0;
         end
         beat.data = $urandom;
         beat.keep = KEEP_W'($urandom);
         beat.user = USER_W'($urandom);
         beat.last = (i == count - 1) || ($urandom_range(4) == 0);
         @(posedge clk);
         {s_tlast_i, s_tuser_i, s_tkeep_i, s_tdata_i} <= beat;
         s_tvalid_i <= 1'b1;
         @(negedge clk);
         room = model_has_room();
         check_flag("s_tready_o", s_tready_o, room);
         if (room) begin
            recorded_q.push_back(beat);
         end
      end
      @(posedge clk);
      s_tvalid_i <= 1'b0;
   endtask

   task automatic close_recording();
      @(posedge clk);
      wr_done_i <= 1'b1;
      @(posedge clk);
      wr_done_i <= 1'b0;
      @(negedge clk);
      check_flag("s_tready_o", s_tready_o, 1'b0);
   endtask

   task automatic apply_sw_rst();
      @(posedge clk);
      sw_rst_i <= 1'b1;
      @(posedge clk);
      sw_rst_i <= 1'b0;
      recorded_q.delete();
      @(negedge clk);
      check_flag("s_tready_o", s_tready_o, 1'b1);
   endtask

   task automatic run_replay(input pass_count_t count, input logic bp, input int exp_beats);
      beat_t got;
      int    received;
      int    cycles;
      int    limit;
      limit = 20 * exp_beats + 50;
      @(posedge clk);
      replay_count_i <= count;
      start_replay_i <= 1'b1;
      @(posedge clk);
      start_replay_i <= 1'b0;
      @(negedge clk);
      check_flag("replay_busy_o", replay_busy_o, (count != 0) && (recorded_q.size() != 0));
      received = 0;
      cycles   = 0;
      while (received < exp_beats && cycles < limit) begin
         @(posedge clk);
         m_tready_i <= bp ? ($urandom_range(2) == 0) : 1'b1;
         @(negedge clk);
         cycles++;
         // Both high here means the beat transfers on the coming edge
         if (m_tvalid_o && m_tready_i) begin
            got = {m_tlast_o, m_tuser_o, m_tkeep_o, m_tdata_o};
            check_beat("m_tlast_o/m_tuser_o/m_tkeep_o/m_tdata_o", got,
                       model_expected(received));
            received++;
         end
      end
      if (received < exp_beats) begin
         report_timeout("all replayed beats", limit);
      end else begin
         cycles = 0;
         while (replay_busy_o && cycles < limit) begin
            @(negedge clk);
            cycles++;
         end
         if (replay_busy_o) begin
            report_timeout("replay_busy_o to fall", limit);
         end else begin
            check_idle(10);
         end
      end
   endtask

   initial begin
      void'($urandom(SEED));
      reset_i        = 1'b1;
      s_tdata_i      = '0;
      s_tkeep_i      = '0;
      s_tuser_i      = '0;
      s_tlast_i      = 1'b0;
      s_tvalid_i     = 1'b0;
      m_tready_i     = 1'b1;
      sw_rst_i       = 1'b0;
      wr_done_i      = 1'b0;
      start_replay_i = 1'b0;
      replay_count_i = '0;
      repeat (4) @(posedge clk);
      reset_i <= 1'b0;
      @(negedge clk);
      check_flag("s_tready_o", s_tready_o, 1'b1);
      check_flag("m_tvalid_o", m_tvalid_o, 1'b0);
      check_flag("replay_busy_o", replay_busy_o, 1'b0);

      for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
         if (ROWS[r].sw_rst_first) begin
            apply_sw_rst();
         end
         if (ROWS[r].n_beats != 0) begin
            record_beats(ROWS[r].n_beats);
            close_recording();
         end
         run_replay(ROWS[r].replay_count, ROWS[r].backpressure, ROWS[r].exp_out_beats);
      end

      $display("Checks: %0d, value errors: %0d, timeouts: %0d",
               check_count, value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- rtl/beat_packer.sv
/*
 * Record side: accepts input beats while recording is open and writes
 * each one as a memory word at the next address
 */
module beat_packer #(
   parameter int ADDR_W = 4
) (
   input  logic                          clk,
   input  logic                          reset_i,
   input  logic                          sw_rst_i,
   input  logic                          wr_done_i,
   input  logic                          replay_active_i,

   input  logic [stream_pkg::DATA_W-1:0] s_tdata_i,
   input  logic [stream_pkg::KEEP_W-1:0] s_tkeep_i,
   input  logic [stream_pkg::USER_W-1:0] s_tuser_i,
   input  logic                          s_tlast_i,
   input  logic                          s_tvalid_i,
   output logic                          s_tready_o,

   output logic                          wr_en_o,
   output mem_pkg::mem_addr_t            wr_addr_o,
   output mem_pkg::mem_word_t            wr_word_o,
   output mem_pkg::word_count_t          stored_count_o,
   output logic                          rec_closed_o
);
   import mem_pkg::*;

   localparam word_count_t DEPTH = word_count_t'(1) << ADDR_W;

   // The count doubles as the write pointer
   word_count_t count_q;
   logic        closed_q;
   logic        accept;
   logic        last_slot;

   // Open until wr_done or full, and held off while replay runs
   assign s_tready_o = ~closed_q & ~replay_active_i & ~sw_rst_i;
   assign accept     = s_tvalid_i & s_tready_o;
   assign last_slot  = (count_q == DEPTH - 1'b1);

   assign wr_en_o   = accept;
   assign wr_addr_o = count_q[MEM_ADDR_W-1:0];

   assign wr_word_o.beat.last = s_tlast_i;
   assign wr_word_o.beat.user = s_tuser_i;
   assign wr_word_o.beat.keep = s_tkeep_i;
   assign wr_word_o.beat.data = s_tdata_i;

   assign stored_count_o = count_q;
   assign rec_closed_o   = closed_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         count_q  <= '0;
         closed_q <= 1'b0;
      end else if (sw_rst_i) begin
         // Software reset drops the recording and reopens the input
         count_q  <= '0;
         closed_q <= 1'b0;
      end else begin
         if (accept) begin
            count_q <= count_q + 1'b1;
         end
         if (wr_done_i || (accept && last_slot)) begin
            closed_q <= 1'b1;
         end
      end
   end

   // The count never runs past the memory depth
   a_count_limit: assert property (@(posedge clk) disable iff (reset_i)
      stored_count_o <= DEPTH)
      else $error("beat_packer: stored count passed depth");

endmodule

//--- rtl/fallthrough_fifo.sv
/*
 * Show-ahead beat FIFO: head entry is on dout_o whenever not empty,
 * with a nearly-full flag for the read issuer
 */
module fallthrough_fifo #(
   parameter int FIFO_DEPTH_BITS = 3
) (
   input  logic              clk,
   input  logic              reset_i,
   input  logic              wr_en_i,
   input  stream_pkg::beat_t din_i,
   input  logic              rd_en_i,
   output stream_pkg::beat_t dout_o,
   output logic              empty_o,
   output logic              nearly_full_o
);
   import stream_pkg::*;

   localparam logic [FIFO_DEPTH_BITS:0] DEPTH = {1'b1, {FIFO_DEPTH_BITS{1'b0}}};
   // Two free slots cover one read in the RAM plus the next issue
   localparam logic [FIFO_DEPTH_BITS:0] NF_LEVEL = DEPTH - 2'd2;

   beat_t                      mem [0:(1<<FIFO_DEPTH_BITS)-1];
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr_q;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr_q;
   logic [FIFO_DEPTH_BITS:0]   count_q;
   logic                       full;

   assign full          = (count_q == DEPTH);
   assign empty_o       = (count_q == '0);
   assign nearly_full_o = (count_q >= NF_LEVEL);

   // Head of queue read combinationally
   assign dout_o = mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_ptr_q] <= din_i;
      end
   end

   // Pointers wrap naturally at the power-of-two depth
   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({wr_en_i, rd_en_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // The sequencer's gating must keep a slot free for every returning read
   a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
      wr_en_i |-> !full)
      else $error("fallthrough_fifo: write while full");

   // The output handshake must only pop a valid head
   a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
      rd_en_i |-> !empty_o)
      else $error("fallthrough_fifo: read while empty");

endmodule

//--- rtl/mem_pkg.sv
/*
 * Packet memory definitions: word layout, address, stored-word count
 * and replay pass count
 */
package mem_pkg;

   // Widest address the buffer supports
   // Each instance narrows it with its own ADDR_W
   localparam int MEM_ADDR_W = 10;

   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

   // One extra bit so a completely full memory can be counted
   typedef logic [MEM_ADDR_W:0] word_count_t;

   // Number of times the stored sequence is played back
   typedef logic [15:0] pass_count_t;

   // One stored word holds a single beat
   // Field order follows the beat: data low, then keep, user, last
   typedef struct packed {
      stream_pkg::beat_t beat;
   } mem_word_t;

endpackage

//--- rtl/packet_ram.sv
/*
 * On-chip packet memory: one write port, one registered read port
 * with a read-valid tag one cycle after the request
 */
module packet_ram #(
   parameter int ADDR_W = 4
) (
   input  logic               clk,
   input  logic               reset_i,
   input  logic               wr_en_i,
   input  mem_pkg::mem_addr_t wr_addr_i,
   input  mem_pkg::mem_word_t wr_word_i,
   input  logic               rd_en_i,
   input  mem_pkg::mem_addr_t rd_addr_i,
   output logic               rd_valid_o,
   output mem_pkg::mem_word_t rd_word_o
);
   import mem_pkg::*;

   mem_word_t mem [0:(1<<ADDR_W)-1];

   // Only the low ADDR_W address bits select a word
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i[ADDR_W-1:0]] <= wr_word_i;
      end
      if (rd_en_i) begin
         rd_word_o <= mem[rd_addr_i[ADDR_W-1:0]];
      end
   end

   // Valid tag follows the request by exactly one cycle
   always_ff @(posedge clk) begin
      if (reset_i) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

endmodule

//--- rtl/replay_sequencer.sv
/*
 * Replay side: walks the stored words in address order for the
 * programmed number of passes, pausing on FIFO back-pressure
 */
module replay_sequencer #(
   parameter int ADDR_W = 4
) (
   input  logic                 clk,
   input  logic                 reset_i,
   input  logic                 start_replay_i,
   input  mem_pkg::pass_count_t replay_count_i,
   input  mem_pkg::word_count_t stored_count_i,
   input  logic                 rec_closed_i,
   input  logic                 fifo_nearly_full_i,
   output logic                 rd_en_o,
   output mem_pkg::mem_addr_t   rd_addr_o,
   output logic                 replay_active_o
);
   import mem_pkg::*;

   logic              active_q;
   logic [ADDR_W-1:0] rd_ptr_q;
   logic [ADDR_W-1:0] last_ptr_q;
   pass_count_t       passes_left_q;
   word_count_t       last_word;
   logic              start_ok;
   logic              pass_end;

   // Start needs an idle sequencer, a closed non-empty recording and passes to run
   assign start_ok = start_replay_i & ~active_q & rec_closed_i &
                     (stored_count_i != '0) & (replay_count_i != '0);

   assign last_word = stored_count_i - 1'b1;
   assign pass_end  = (rd_ptr_q == last_ptr_q);

   assign rd_en_o         = active_q & ~fifo_nearly_full_i;
   assign rd_addr_o       = mem_addr_t'(rd_ptr_q);
   assign replay_active_o = active_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         active_q      <= 1'b0;
         rd_ptr_q      <= '0;
         last_ptr_q    <= '0;
         passes_left_q <= '0;
      end else if (start_ok) begin
         active_q      <= 1'b1;
         rd_ptr_q      <= '0;
         // Latched so a later sw_rst cannot stretch the pass
         last_ptr_q    <= last_word[ADDR_W-1:0];
         passes_left_q <= replay_count_i;
      end else if (rd_en_o) begin
         if (pass_end) begin
            rd_ptr_q      <= '0;
            passes_left_q <= passes_left_q - 1'b1;
            if (passes_left_q == pass_count_t'(1)) begin
               active_q <= 1'b0;
            end
         end else begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // While the FIFO is nearly full the read pointer does not move
   a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
      active_q && fifo_nearly_full_i |=> $stable(rd_ptr_q))
      else $error("replay_sequencer: read issued while FIFO nearly full");

endmodule

//--- rtl/replay_top.sv
/*
 * Record-and-replay buffer: captures stream beats into on-chip RAM and
 * plays the stored sequence back a programmed number of times
 */
module replay_top #(
   parameter int ADDR_W          = 4,
   parameter int FIFO_DEPTH_BITS = 3
) (
   input  logic                          clk,
   input  logic                          reset_i,

   input  logic [stream_pkg::DATA_W-1:0] s_tdata_i,
   input  logic [stream_pkg::KEEP_W-1:0] s_tkeep_i,
   input  logic [stream_pkg::USER_W-1:0] s_tuser_i,
   input  logic                          s_tlast_i,
   input  logic                          s_tvalid_i,
   output logic                          s_tready_o,

   output logic [stream_pkg::DATA_W-1:0] m_tdata_o,
   output logic [stream_pkg::KEEP_W-1:0] m_tkeep_o,
   output logic [stream_pkg::USER_W-1:0] m_tuser_o,
   output logic                          m_tlast_o,
   output logic                          m_tvalid_o,
   input  logic                          m_tready_i,

   input  logic                          sw_rst_i,
   input  logic                          wr_done_i,
   input  logic                          start_replay_i,
   input  mem_pkg::pass_count_t          replay_count_i,
   output logic                          replay_busy_o
);
   import stream_pkg::*;
   import mem_pkg::*;

   logic        wr_en;
   mem_addr_t   wr_addr;
   mem_word_t   wr_word;
   word_count_t stored_count;
   logic        rec_closed;

   logic        rd_en;
   mem_addr_t   rd_addr;
   logic        rd_valid;
   mem_word_t   rd_word;

   logic        replay_active;
   logic        nearly_full;
   logic        fifo_empty;
   beat_t       fifo_dout;

   beat_packer #(.ADDR_W(ADDR_W)) u_packer (
      .clk              (clk),
      .reset_i          (reset_i),
      .sw_rst_i         (sw_rst_i),
      .wr_done_i        (wr_done_i),
      .replay_active_i  (replay_active),
      .s_tdata_i        (s_tdata_i),
      .s_tkeep_i        (s_tkeep_i),
      .s_tuser_i        (s_tuser_i),
      .s_tlast_i        (s_tlast_i),
      .s_tvalid_i       (s_tvalid_i),
      .s_tready_o       (s_tready_o),
      .wr_en_o          (wr_en),
      .wr_addr_o        (wr_addr),
      .wr_word_o        (wr_word),
      .stored_count_o   (stored_count),
      .rec_closed_o     (rec_closed)
   );

   packet_ram #(.ADDR_W(ADDR_W)) u_ram (
      .clk              (clk),
      .reset_i          (reset_i),
      .wr_en_i          (wr_en),
      .wr_addr_i        (wr_addr),
      .wr_word_i        (wr_word),
      .rd_en_i          (rd_en),
      .rd_addr_i        (rd_addr),
      .rd_valid_o       (rd_valid),
      .rd_word_o        (rd_word)
   );

   replay_sequencer #(.ADDR_W(ADDR_W)) u_sequencer (
      .clk                 (clk),
      .reset_i             (reset_i),
      .start_replay_i      (start_replay_i),
      .replay_count_i      (replay_count_i),
      .stored_count_i      (stored_count),
      .rec_closed_i        (rec_closed),
      .fifo_nearly_full_i  (nearly_full),
      .rd_en_o             (rd_en),
      .rd_addr_o           (rd_addr),
      .replay_active_o     (replay_active)
   );

   // Read data goes straight into the FIFO, the sequencer keeps room for it
   fallthrough_fifo #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) u_out_fifo (
      .clk              (clk),
      .reset_i          (reset_i),
      .wr_en_i          (rd_valid),
      .din_i            (rd_word.beat),
      .rd_en_i          (m_tready_i & ~fifo_empty),
      .dout_o           (fifo_dout),
      .empty_o          (fifo_empty),
      .nearly_full_o    (nearly_full)
   );

   assign m_tvalid_o    = ~fifo_empty;
   assign m_tdata_o     = fifo_dout.data;
   assign m_tkeep_o     = fifo_dout.keep;
   assign m_tuser_o     = fifo_dout.user;
   assign m_tlast_o     = fifo_dout.last;

   assign replay_busy_o = replay_active;

endmodule

//--- rtl/stream_pkg.sv
/*
 * Stream beat definitions shared by the record path, the replay path
 * and the output port
 */
package stream_pkg;

   // Payload and sideband widths of one beat
   localparam int DATA_W = 32;
   localparam int KEEP_W = DATA_W / 8;
   localparam int USER_W = 8;

   // One stream beat, 45 bits
   // Data sits in the low bits, then keep, user and last on top,
   // the same order as the stored memory word
   typedef struct packed {
      logic              last;
      logic [USER_W-1:0] user;
      logic [KEEP_W-1:0] keep;
      logic [DATA_W-1:0] data;
   } beat_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build the replay buffer testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module replay_tb \
   -f verilog.f -Mdir obj_dir || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vreplay_tb)
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- verilog.f
+incdir+bench
rtl/stream_pkg.sv
rtl/mem_pkg.sv
rtl/beat_packer.sv
rtl/packet_ram.sv
rtl/replay_sequencer.sv
rtl/fallthrough_fifo.sv
rtl/replay_top.sv
bench/replay_tb.sv
